/* bench/tb_dbus_subsys.sv */
`timescale 1ns/100ps

module tb_dbus_subsys;

   logic              clk;
   logic              rst_i;
   logic              ld_req_i;
   dbus_pkg::st_ops_t st_ops_i;
   dbus_pkg::addr_t   addr_i;
   dbus_pkg::data_t   w_data_i;
   dbus_pkg::data_t   r_data_o;
   logic              ack_o;
   logic              uart_tx_o;
   logic              timer_irq_o;

   logic [31:0]       lfsr_q;
   logic [7:0]        ref_bytes [0:1023];   // Byte image of the low dmem
   int                err_cnt;
   int                test_err_base;
   int                tests_passed;
   int                tests_failed;
   dbus_pkg::addr_t   last_word_addr;

   dbus_subsys_top dut0 (
      .clk         (clk),
      .rst_i       (rst_i),
      .ld_req_i    (ld_req_i),
      .st_ops_i    (st_ops_i),
      .addr_i      (addr_i),
      .w_data_i    (w_data_i),
      .r_data_o    (r_data_o),
      .ack_o       (ack_o),
      .uart_tx_o   (uart_tx_o),
      .timer_irq_o (timer_irq_o)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
   function automatic logic [31:0] rand_bits(int n);
      logic [31:0] val;
      logic        fb;
      val = '0;
      for (int i = 0; i < n; i++) begin
         fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
         lfsr_q = {lfsr_q[30:0], fb};
         val    = {val[30:0], fb};
      end
      return val;
   endfunction

   // SB hits one byte, SH an aligned half and SW the whole word
   function automatic void model_store(dbus_pkg::addr_t addr, dbus_pkg::st_ops_t op,
                                       dbus_pkg::data_t wdata);
      logic [9:0] ba;
      ba = addr[9:0];
      case (op)
         dbus_pkg::ST_OPS_SB: ref_bytes[ba] = wdata[7:0];
         dbus_pkg::ST_OPS_SH: begin
            ba                   = {addr[9:1], 1'b0};
            ref_bytes[ba]        = wdata[7:0];
            ref_bytes[ba | 10'd1] = wdata[15:8];
         end
         dbus_pkg::ST_OPS_SW: begin
            ba                   = {addr[9:2], 2'b00};
            ref_bytes[ba]        = wdata[7:0];
            ref_bytes[ba | 10'd1] = wdata[15:8];
            ref_bytes[ba | 10'd2] = wdata[23:16];
            ref_bytes[ba | 10'd3] = wdata[31:24];
         end
         default: ;
      endcase
   endfunction

   function automatic dbus_pkg::data_t model_word(dbus_pkg::addr_t addr);
      logic [9:0] ba;
      ba = {addr[9:2], 2'b00};
      return {ref_bytes[ba | 10'd3], ref_bytes[ba | 10'd2], ref_bytes[ba | 10'd1], ref_bytes[ba]};
   endfunction

   task automatic check_data(string name, dbus_pkg::data_t exp, dbus_pkg::data_t act);
      if (act !== exp) begin
         $display("Fail %s: expected %08h, got %08h", name, exp, act);
         err_cnt++;
      end
   endtask

   task automatic check_bit(string name, logic exp, logic act);
      if (act !== exp) begin
         $display("Fail %s: expected %h, got %h", name, exp, act);
         err_cnt++;
      end
   endtask

   task automatic report_problem(string msg);
      $display("Error: %s", msg);
      err_cnt++;
   endtask

   task automatic start_test();
      test_err_base = err_cnt;
   endtask

   task automatic end_test(string name);
      if (err_cnt == test_err_base) begin
         tests_passed++;
         $display("%s: passed", name);
      end else begin
         tests_failed++;
         $display("%s: failed with %0d errors", name, err_cnt - test_err_base);
      end
   endtask

   // Latency 0 means the request was never acked
   task automatic run_request(logic ld, dbus_pkg::st_ops_t op, dbus_pkg::addr_t addr,
                              dbus_pkg::data_t wdata, int limit,
                              output dbus_pkg::data_t rdata, output int latency);
      ld_req_i = ld;
      st_ops_i = op;
      addr_i   = addr;
      w_data_i = wdata;
      latency  = 0;
      rdata    = '0;
      for (int cyc = 1; cyc <= limit && latency == 0; cyc++) begin
         @(negedge clk);
         if (ack_o) begin
            latency = cyc;
            rdata   = r_data_o;
         end
      end
      if (latency != 0) @(negedge clk);            // Held through the acking edge
      ld_req_i = 1'b0;
      st_ops_i = dbus_pkg::ST_OPS_NONE;
      addr_i   = '0;
      w_data_i = '0;
   endtask

   task automatic bus_store(dbus_pkg::addr_t addr, dbus_pkg::st_ops_t op,
                            dbus_pkg::data_t wdata, output int latency);
      dbus_pkg::data_t unused;
      run_request(1'b0, op, addr, wdata, 50, unused, latency);
      if (latency == 0) report_problem($sformatf("store to %08h was never acknowledged", addr));
   endtask

   task automatic bus_load(dbus_pkg::addr_t addr, output dbus_pkg::data_t rdata,
                           output int latency);
      run_request(1'b1, dbus_pkg::ST_OPS_NONE, addr, '0, 50, rdata, latency);
      if (latency == 0) report_problem($sformatf("load from %08h was never acknowledged", addr));
   endtask

   task automatic expect_one_cycle(string what, dbus_pkg::addr_t addr, int latency);
      if (latency > 1) begin
         report_problem($sformatf("%s at %08h took %0d cycles to ack", what, addr, latency));
      end
   endtask

   task automatic test_word_round_trip();
      dbus_pkg::addr_t addr;
      dbus_pkg::data_t wdata;
      dbus_pkg::data_t rdata;
      logic [7:0]      idx;
      int              lat;
      start_test();
      for (int i = 0; i < 16; i++) begin
         idx   = 8'(rand_bits(8));
         addr  = {dbus_pkg::DMEM_ADDR_MATCH, 18'h0, idx, 2'b00};
         wdata = rand_bits(32);
         bus_store(addr, dbus_pkg::ST_OPS_SW, wdata, lat);
         model_store(addr, dbus_pkg::ST_OPS_SW, wdata);
         expect_one_cycle("store", addr, lat);
         bus_load(addr, rdata, lat);
         expect_one_cycle("load", addr, lat);
         check_data("r_data_o", model_word(addr), rdata);
      end
      last_word_addr = addr;
      end_test("word round trip");
   endtask

   task automatic test_lane_steering();
      dbus_pkg::addr_t addr;
      dbus_pkg::addr_t sub_addr;
      dbus_pkg::data_t wdata;
      dbus_pkg::data_t rdata;
      logic [7:0]      idx;
      int              lat;
      start_test();
      idx   = 8'(rand_bits(8));
      addr  = {dbus_pkg::DMEM_ADDR_MATCH, 18'h0, idx, 2'b00};
      wdata = rand_bits(32);
      bus_store(addr, dbus_pkg::ST_OPS_SW, wdata, lat);
      model_store(addr, dbus_pkg::ST_OPS_SW, wdata);
      for (int ofs = 0; ofs < 6; ofs++) begin
         wdata = rand_bits(32);                   // Upper bits must not leak
         if (ofs < 4) begin
            sub_addr = addr | ofs;
            bus_store(sub_addr, dbus_pkg::ST_OPS_SB, wdata, lat);
            model_store(sub_addr, dbus_pkg::ST_OPS_SB, wdata);
         end else begin
            sub_addr = addr | (2 * (ofs - 4));
            bus_store(sub_addr, dbus_pkg::ST_OPS_SH, wdata, lat);
            model_store(sub_addr, dbus_pkg::ST_OPS_SH, wdata);
         end
         bus_load(addr, rdata, lat);
         check_data("r_data_o", model_word(addr), rdata);
      end
      end_test("lane steering");
   endtask

   task automatic test_unmapped();
      dbus_pkg::addr_t addr;
      dbus_pkg::data_t rdata;
      int              lat;
      start_test();
      addr = {4'h5, last_word_addr[27:0]};        // Same offset as a live dmem word
      run_request(1'b1, dbus_pkg::ST_OPS_NONE, addr, '0, 20, rdata, lat);
      if (lat != 0) report_problem("load from an unmapped address was acknowledged");
      run_request(1'b0, dbus_pkg::ST_OPS_SW, addr, ~model_word(last_word_addr), 20, rdata, lat);
      if (lat != 0) report_problem("store to an unmapped address was acknowledged");
      bus_load(last_word_addr, rdata, lat);
      check_data("r_data_o", model_word(last_word_addr), rdata);
      end_test("unmapped address");
   endtask

   task automatic test_clint();
      dbus_pkg::addr_t base;
      dbus_pkg::data_t t0;
      dbus_pkg::data_t t1;
      dbus_pkg::data_t t_hi;
      logic [63:0]     cmp;
      int              lat;
      int              waited;
      start_test();
      base = {dbus_pkg::CLINT_ADDR_MATCH, 28'h0};
      check_bit("timer_irq_o", 1'b0, timer_irq_o);
      bus_load(base | 32'(dbus_pkg::CLINT_MTIME_LO_OFS), t0, lat);
      repeat (30) @(negedge clk);
      bus_load(base | 32'(dbus_pkg::CLINT_MTIME_LO_OFS), t1, lat);
      // The two reads sample mtime 32 cycles apart
      if (t1 - t0 < 32'd32) begin
         report_problem($sformatf("mtime advanced only %0d in 32 cycles", t1 - t0));
      end
      bus_load(base | 32'(dbus_pkg::CLINT_MTIME_LO_OFS), t0, lat);
      bus_load(base | 32'(dbus_pkg::CLINT_MTIME_HI_OFS), t_hi, lat);
      cmp = {t_hi, t0} + 64'd40;
      bus_store(base | 32'(dbus_pkg::CLINT_MTIMECMP_LO_OFS), dbus_pkg::ST_OPS_SW, cmp[31:0], lat);
      bus_store(base | 32'(dbus_pkg::CLINT_MTIMECMP_HI_OFS), dbus_pkg::ST_OPS_SW, cmp[63:32], lat);
      check_bit("timer_irq_o", 1'b0, timer_irq_o);
      waited = 0;
      while (!timer_irq_o && waited < 60) begin
         @(negedge clk);
         waited++;
      end
      check_bit("timer_irq_o", 1'b1, timer_irq_o);
      end_test("clint timer");
   endtask

   task automatic test_uart();
      dbus_pkg::addr_t base;
      dbus_pkg::data_t status;
      logic [7:0]      tx_byte;
      logic [9:0]      exp_frame;
      logic [9:0]      got_frame;
      int              lat;
      start_test();
      base = {dbus_pkg::UART_ADDR_MATCH, 28'h0};
      check_bit("uart_tx_o", 1'b1, uart_tx_o);
      bus_store(base | 32'(dbus_pkg::UART_DIV_OFS), dbus_pkg::ST_OPS_SW, 32'd4, lat);
      tx_byte   = 8'(rand_bits(8));
      exp_frame = {1'b1, tx_byte, 1'b0};          // Stop, data, start
      got_frame = '0;
      fork
         begin
            @(negedge uart_tx_o);
            repeat (2) @(negedge clk);            // Near the middle of each 4-cycle bit
            for (int b = 0; b < 10; b++) begin
               got_frame = {uart_tx_o, got_frame[9:1]};
               if (b < 9) repeat (4) @(negedge clk);
            end
         end
         begin
            bus_store(base | 32'(dbus_pkg::UART_TXDATA_OFS), dbus_pkg::ST_OPS_SW,
                      {24'(rand_bits(24)), tx_byte}, lat);
            bus_load(base | 32'(dbus_pkg::UART_STATUS_OFS), status, lat);
            check_data("r_data_o", 32'h1, status);
         end
      join
      for (int b = 0; b < 10; b++) begin
         check_bit($sformatf("uart_tx_o bit %0d", b), exp_frame[0], got_frame[0]);
         exp_frame = exp_frame >> 1;
         got_frame = got_frame >> 1;
      end
      repeat (6) @(negedge clk);
      bus_load(base | 32'(dbus_pkg::UART_STATUS_OFS), status, lat);
      check_data("r_data_o", 32'h0, status);
      check_bit("uart_tx_o", 1'b1, uart_tx_o);
      end_test("uart transmit");
   endtask

   // Rough cycles are 12 for reset, 64 words, 26 lanes, 42 unmapped, 110 clint and 60 uart
   initial begin
      int budget;
      budget = 2 * (12 + 64 + 26 + 42 + 110 + 60) + 100;
      #(budget * 10);
      $display("Watchdog expired after %0d cycles, the run did not finish", budget);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   initial begin
      lfsr_q       = 32'h9d000b53;
      err_cnt      = 0;
      tests_passed = 0;
      tests_failed = 0;
      rst_i        = 1'b1;
      ld_req_i     = 1'b0;
      st_ops_i     = dbus_pkg::ST_OPS_NONE;
      addr_i       = '0;
      w_data_i     = '0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_i = 1'b0;
      @(negedge clk);
      test_word_round_trip();
      test_lane_steering();
      test_unmapped();
      test_clint();
      test_uart();
      $display("Tests passed %0d, failed %0d, check errors %0d",
               tests_passed, tests_failed, err_cnt);
      if (err_cnt == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule : tb_dbus_subsys

/* run.sh */
#!/usr/bin/env bash
# Build and run the data bus testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_dbus_subsys \
   -o tb_dbus_subsys || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/tb_dbus_subsys)"
echo "$sim_out"
echo "$sim_out" | grep -qx "TEST RESULT: PASS" && exit 0 || exit 1

/* sim.f */
source/dbus_pkg.sv
source/dbus_interconnect.sv
source/data_mem.sv
source/uart_tx_periph.sv
source/clint_timer.sv
source/dbus_subsys_top.sv
bench/tb_dbus_subsys.sv

/* source/clint_timer.sv */
`timescale 1ns/100ps

module clint_timer (
   input  logic                clk,
   input  logic                rst_i,
   input  logic                sel_i,
   input  logic                stb_i,
   input  logic                w_en_i,
   input  dbus_pkg::addr_t     addr_i,
   input  dbus_pkg::data_t     w_data_i,
   input  dbus_pkg::sel_byte_t sel_byte_i,
   output dbus_pkg::data_t     r_data_o,
   output logic                ack_o,
   output logic                timer_irq_o
);

   logic            ack_q;
   logic            access;
   logic            wr;
   logic [15:0]     reg_ofs;
   logic [63:0]     mtime_q;
   logic [63:0]     mtimecmp_q;
   logic            irq_q;
   dbus_pkg::data_t cmp_lo_next;
   dbus_pkg::data_t cmp_hi_next;
   dbus_pkg::data_t r_data_q;

   assign access  = sel_i & stb_i & ~ack_q;
   assign wr      = access & w_en_i;
   assign reg_ofs = addr_i[15:0];

   assign cmp_lo_next = dbus_pkg::byte_merge(mtimecmp_q[31:0], w_data_i, sel_byte_i);
   assign cmp_hi_next = dbus_pkg::byte_merge(mtimecmp_q[63:32], w_data_i, sel_byte_i);

   always_ff @(posedge clk) begin
      if (rst_i) begin
         ack_q      <= 1'b0;
         mtime_q    <= '0;
         mtimecmp_q <= '1;                         // Keeps irq off after reset
         irq_q      <= 1'b0;
      end else begin
         ack_q   <= access;
         mtime_q <= mtime_q + 64'd1;               // Free running
         if (wr && reg_ofs == dbus_pkg::CLINT_MTIMECMP_LO_OFS) begin
            mtimecmp_q[31:0] <= cmp_lo_next;
         end
         if (wr && reg_ofs == dbus_pkg::CLINT_MTIMECMP_HI_OFS) begin
            mtimecmp_q[63:32] <= cmp_hi_next;
         end
         irq_q <= (mtime_q >= mtimecmp_q);
      end
   end

   always_ff @(posedge clk) begin
      if (access && !w_en_i) begin
         case (reg_ofs)
            dbus_pkg::CLINT_MTIMECMP_LO_OFS: r_data_q <= mtimecmp_q[31:0];
            dbus_pkg::CLINT_MTIMECMP_HI_OFS: r_data_q <= mtimecmp_q[63:32];
            dbus_pkg::CLINT_MTIME_LO_OFS:    r_data_q <= mtime_q[31:0];
            dbus_pkg::CLINT_MTIME_HI_OFS:    r_data_q <= mtime_q[63:32];
            default:                         r_data_q <= '0;
         endcase
      end
   end

   assign r_data_o    = r_data_q;
   assign ack_o       = ack_q;
   assign timer_irq_o = irq_q;

endmodule : clint_timer

/* source/data_mem.sv */
`timescale 1ns/100ps

module data_mem (
   input  logic                clk,
   input  logic                rst_i,
   input  logic                sel_i,
   input  logic                stb_i,
   input  logic                w_en_i,
   input  dbus_pkg::addr_t     addr_i,
   input  dbus_pkg::data_t     w_data_i,
   input  dbus_pkg::sel_byte_t sel_byte_i,
   output dbus_pkg::data_t     r_data_o,
   output logic                ack_o
);

   dbus_pkg::data_t                  mem [dbus_pkg::DMEM_WORDS];
   dbus_pkg::data_t                  r_data_q;
   logic                             ack_q;
   logic                             access;
   logic [dbus_pkg::DMEM_IDX_BITS-1:0] word_idx;

   assign word_idx = addr_i[dbus_pkg::DMEM_IDX_BITS+1:2];

   // A set ack blocks the held request for one cycle
   assign access = sel_i & stb_i & ~ack_q;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   // Byte-lane writes and registered reads
   always_ff @(posedge clk) begin
      if (access) begin
         if (w_en_i) begin
            mem[word_idx] <= dbus_pkg::byte_merge(mem[word_idx], w_data_i, sel_byte_i);
         end else begin
            r_data_q <= mem[word_idx];             // Registered read
         end
      end
   end

   assign r_data_o = r_data_q;
   assign ack_o    = ack_q;

   a_ack_after_stb: assert property (@(posedge clk) disable iff (rst_i)
      ack_o |-> $past(sel_i && stb_i))
      else $error("dmem ack without a selected strobe");

endmodule : data_mem

/* source/dbus_interconnect.sv */
`timescale 1ns/100ps

module dbus_interconnect (
   input  logic                clk,
   input  logic                rst_i,

   // Requester side
   input  logic                ld_req_i,
   input  dbus_pkg::st_ops_t   st_ops_i,
   input  dbus_pkg::addr_t     addr_i,
   input  dbus_pkg::data_t     w_data_i,
   output dbus_pkg::data_t     r_data_o,
   output logic                ack_o,

   // Shared slave lines
   output dbus_pkg::addr_t     dbus_addr_o,
   output dbus_pkg::data_t     dbus_w_data_o,
   output dbus_pkg::sel_byte_t dbus_sel_byte_o,
   output logic                dbus_cyc_o,
   output logic                dbus_stb_o,
   output logic                dbus_w_en_o,

   output logic                dmem_sel_o,
   output logic                uart_sel_o,
   output logic                clint_sel_o,

   input  dbus_pkg::data_t     dmem_r_data_i,
   input  dbus_pkg::data_t     uart_r_data_i,
   input  dbus_pkg::data_t     clint_r_data_i,
   input  logic                dmem_ack_i,
   input  logic                uart_ack_i,
   input  logic                clint_ack_i
);

   logic               st_req;
   logic               dbus_req;
   dbus_pkg::dev_sel_t dev_sel;

   assign st_req   = (st_ops_i != dbus_pkg::ST_OPS_NONE);
   assign dbus_req = ld_req_i | st_req;
   assign dev_sel  = addr_i[dbus_pkg::DEV_SEL_ADDR_HIGH:dbus_pkg::DEV_SEL_ADDR_LOW];

   // Store data steering into byte lanes
   always_comb begin
      dbus_w_data_o   = '0;
      dbus_sel_byte_o = 4'b0000;
      case (st_ops_i)
         dbus_pkg::ST_OPS_SB: begin
            dbus_w_data_o[addr_i[1:0]*8 +: 8] = w_data_i[7:0];
            dbus_sel_byte_o = 4'b0001 << addr_i[1:0];
         end
         dbus_pkg::ST_OPS_SH: begin
            if (addr_i[1]) begin
               dbus_w_data_o[31:16] = w_data_i[15:0];
               dbus_sel_byte_o      = 4'b1100;
            end else begin
               dbus_w_data_o[15:0] = w_data_i[15:0];
               dbus_sel_byte_o     = 4'b0011;
            end
         end
         dbus_pkg::ST_OPS_SW: begin
            dbus_w_data_o   = w_data_i;
            dbus_sel_byte_o = 4'b1111;
         end
         default: ;                                  // Loads carry no data
      endcase
   end

   // Priority decode, dmem first
   always_comb begin
      dmem_sel_o  = 1'b0;
      clint_sel_o = 1'b0;
      uart_sel_o  = 1'b0;
      if (dbus_req) begin
         if (dev_sel == dbus_pkg::DMEM_ADDR_MATCH) dmem_sel_o = 1'b1;
         else if (dev_sel == dbus_pkg::CLINT_ADDR_MATCH) clint_sel_o = 1'b1;
         else if (dev_sel == dbus_pkg::UART_ADDR_MATCH) uart_sel_o = 1'b1;
      end
   end

   assign dbus_addr_o = addr_i;
   assign dbus_cyc_o  = dbus_req;
   assign dbus_stb_o  = dmem_sel_o | uart_sel_o | clint_sel_o;
   assign dbus_w_en_o = st_req;

   // Return path from the selected slave, zero when unmapped
   always_comb begin
      if (dmem_sel_o) begin
         r_data_o = dmem_r_data_i;
         ack_o    = dmem_ack_i;
      end else if (clint_sel_o) begin
         r_data_o = clint_r_data_i;
         ack_o    = clint_ack_i;
      end else if (uart_sel_o) begin
         r_data_o = uart_r_data_i;
         ack_o    = uart_ack_i;
      end else begin
         r_data_o = '0;
         ack_o    = 1'b0;
      end
   end

   a_sel_onehot: assert property (@(posedge clk) disable iff (rst_i)
      $onehot0({dmem_sel_o, uart_sel_o, clint_sel_o}))
      else $error("More than one slave selected");

   // Slave acks must never leak out without a live request
   a_ack_needs_req: assert property (@(posedge clk) disable iff (rst_i)
      ack_o |-> dbus_req)
      else $error("Acknowledge without request");

endmodule : dbus_interconnect

/* source/dbus_pkg.sv */
package dbus_pkg;

   typedef logic [31:0] addr_t;     // Byte address on the data bus
   typedef logic [31:0] data_t;
   typedef logic [3:0]  sel_byte_t; // One bit per byte lane
   typedef logic [3:0]  dev_sel_t;

   typedef enum logic [1:0] {
      ST_OPS_NONE = 2'b00,
      ST_OPS_SB   = 2'b01,
      ST_OPS_SH   = 2'b10,
      ST_OPS_SW   = 2'b11
   } st_ops_t;

   // Device select field is the top address nibble
   localparam int DEV_SEL_ADDR_HIGH = 31;
   localparam int DEV_SEL_ADDR_LOW  = 28;

   localparam dev_sel_t DMEM_ADDR_MATCH  = 4'h8;
   localparam dev_sel_t UART_ADDR_MATCH  = 4'h9;
   localparam dev_sel_t CLINT_ADDR_MATCH = 4'h2;

   localparam int DMEM_WORDS    = 256;
   localparam int DMEM_IDX_BITS = $clog2(DMEM_WORDS);

   // UART register offsets
   localparam logic [11:0] UART_TXDATA_OFS = 12'h000;
   localparam logic [11:0] UART_STATUS_OFS = 12'h004;
   localparam logic [11:0] UART_DIV_OFS    = 12'h008;
   localparam logic [15:0] UART_DIV_RESET  = 16'd16;

   // CLINT register offsets
   localparam logic [15:0] CLINT_MTIMECMP_LO_OFS = 16'h4000;
   localparam logic [15:0] CLINT_MTIMECMP_HI_OFS = 16'h4004;
   localparam logic [15:0] CLINT_MTIME_LO_OFS    = 16'hBFF8;
   localparam logic [15:0] CLINT_MTIME_HI_OFS    = 16'hBFFC;

   // Replace the enabled byte lanes of a word
   function automatic data_t byte_merge(data_t old_word, data_t new_word, sel_byte_t sel);
      data_t merged;
      merged = old_word;
      for (int i = 0; i < 4; i++) begin
         if (sel[i]) merged[i*8 +: 8] = new_word[i*8 +: 8];
      end
      return merged;
   endfunction

endpackage : dbus_pkg

/* source/dbus_subsys_top.sv */
`timescale 1ns/100ps

module dbus_subsys_top (
   input  logic              clk,
   input  logic              rst_i,
   input  logic              ld_req_i,
   input  dbus_pkg::st_ops_t st_ops_i,
   input  dbus_pkg::addr_t   addr_i,
   input  dbus_pkg::data_t   w_data_i,
   output dbus_pkg::data_t   r_data_o,
   output logic              ack_o,
   output logic              uart_tx_o,
   output logic              timer_irq_o
);

   dbus_pkg::addr_t     dbus_addr;
   dbus_pkg::data_t     dbus_w_data;
   dbus_pkg::sel_byte_t dbus_sel_byte;
   logic                dbus_cyc;
   logic                dbus_stb;
   logic                dbus_w_en;
   logic                dmem_sel;
   logic                uart_sel;
   logic                clint_sel;
   dbus_pkg::data_t     dmem_r_data;
   dbus_pkg::data_t     uart_r_data;
   dbus_pkg::data_t     clint_r_data;
   logic                dmem_ack;
   logic                uart_ack;
   logic                clint_ack;

   dbus_interconnect u_dbus_interconnect (
      .clk             (clk),
      .rst_i           (rst_i),
      .ld_req_i        (ld_req_i),
      .st_ops_i        (st_ops_i),
      .addr_i          (addr_i),
      .w_data_i        (w_data_i),
      .r_data_o        (r_data_o),
      .ack_o           (ack_o),
      .dbus_addr_o     (dbus_addr),
      .dbus_w_data_o   (dbus_w_data),
      .dbus_sel_byte_o (dbus_sel_byte),
      .dbus_cyc_o      (dbus_cyc),
      .dbus_stb_o      (dbus_stb),
      .dbus_w_en_o     (dbus_w_en),
      .dmem_sel_o      (dmem_sel),
      .uart_sel_o      (uart_sel),
      .clint_sel_o     (clint_sel),
      .dmem_r_data_i   (dmem_r_data),
      .uart_r_data_i   (uart_r_data),
      .clint_r_data_i  (clint_r_data),
      .dmem_ack_i      (dmem_ack),
      .uart_ack_i      (uart_ack),
      .clint_ack_i     (clint_ack)
   );

   data_mem u_data_mem (
      .clk        (clk),
      .rst_i      (rst_i),
      .sel_i      (dmem_sel),
      .stb_i      (dbus_stb),
      .w_en_i     (dbus_w_en),
      .addr_i     (dbus_addr),
      .w_data_i   (dbus_w_data),
      .sel_byte_i (dbus_sel_byte),
      .r_data_o   (dmem_r_data),
      .ack_o      (dmem_ack)
   );

   uart_tx_periph u_uart_tx_periph (
      .clk        (clk),
      .rst_i      (rst_i),
      .sel_i      (uart_sel),
      .stb_i      (dbus_stb),
      .w_en_i     (dbus_w_en),
      .addr_i     (dbus_addr),
      .w_data_i   (dbus_w_data),
      .sel_byte_i (dbus_sel_byte),
      .r_data_o   (uart_r_data),
      .ack_o      (uart_ack),
      .tx_o       (uart_tx_o)
   );

   clint_timer u_clint_timer (
      .clk         (clk),
      .rst_i       (rst_i),
      .sel_i       (clint_sel),
      .stb_i       (dbus_stb),
      .w_en_i      (dbus_w_en),
      .addr_i      (dbus_addr),
      .w_data_i    (dbus_w_data),
      .sel_byte_i  (dbus_sel_byte),
      .r_data_o    (clint_r_data),
      .ack_o       (clint_ack),
      .timer_irq_o (timer_irq_o)
   );

   // A fresh mapped bus cycle is acknowledged on the next edge
   a_one_cycle_ack: assert property (@(posedge clk) disable iff (rst_i)
      ($rose(dbus_cyc) && dbus_stb) |=> ack_o)
      else $error("Mapped request not acknowledged in one cycle");

endmodule : dbus_subsys_top

/* source/uart_tx_periph.sv */
`timescale 1ns/100ps

module uart_tx_periph (
   input  logic                clk,
   input  logic                rst_i,
   input  logic                sel_i,
   input  logic                stb_i,
   input  logic                w_en_i,
   input  dbus_pkg::addr_t     addr_i,
   input  dbus_pkg::data_t     w_data_i,
   input  dbus_pkg::sel_byte_t sel_byte_i,
   output dbus_pkg::data_t     r_data_o,
   output logic                ack_o,
   output logic                tx_o
);

   logic            ack_q;
   logic            access;
   logic [11:0]     reg_ofs;
   dbus_pkg::data_t r_data_q;
   dbus_pkg::data_t div_merged;
   logic [15:0]     div_q;
   logic [15:0]     baud_cnt_q;
   logic [3:0]      bit_cnt_q;
   logic [9:0]      shift_q;
   logic            busy;
   logic            baud_tick;
   logic            tx_start;

   assign access  = sel_i & stb_i & ~ack_q;
   assign reg_ofs = addr_i[11:0];
   assign busy    = (bit_cnt_q != 4'd0);

   // Bit period is div cycles, a divisor of zero acts as one
   assign baud_tick = ({1'b0, baud_cnt_q} + 17'd1) >= {1'b0, div_q};

   assign tx_start = access & w_en_i & sel_byte_i[0] & ~busy
                   & (reg_ofs == dbus_pkg::UART_TXDATA_OFS);

   assign div_merged = dbus_pkg::byte_merge({16'h0, div_q}, w_data_i, sel_byte_i);

   always_ff @(posedge clk) begin
      if (rst_i) begin
         ack_q      <= 1'b0;
         div_q      <= dbus_pkg::UART_DIV_RESET;
         baud_cnt_q <= '0;
         bit_cnt_q  <= '0;
         shift_q    <= '1;                         // Line idles high
      end else begin
         ack_q <= access;
         if (access && w_en_i && reg_ofs == dbus_pkg::UART_DIV_OFS) begin
            div_q <= div_merged[15:0];
         end
         if (tx_start) begin
            shift_q    <= {1'b1, w_data_i[7:0], 1'b0}; // Stop, data, start
            bit_cnt_q  <= 4'd10;
            baud_cnt_q <= '0;
         end else if (busy) begin
            if (baud_tick) begin
               shift_q    <= {1'b1, shift_q[9:1]};
               bit_cnt_q  <= bit_cnt_q - 4'd1;
               baud_cnt_q <= '0;
            end else begin
               baud_cnt_q <= baud_cnt_q + 16'd1;
            end
         end
      end
   end

   // Register reads
   always_ff @(posedge clk) begin
      if (access && !w_en_i) begin
         case (reg_ofs)
            dbus_pkg::UART_STATUS_OFS: r_data_q <= {31'h0, busy};
            dbus_pkg::UART_DIV_OFS:    r_data_q <= {16'h0, div_q};
            default:                   r_data_q <= '0;
         endcase
      end
   end

   assign r_data_o = r_data_q;
   assign ack_o    = ack_q;
   assign tx_o     = shift_q[0];

endmodule : uart_tx_periph
